// ==== rtl/core_defines.svh ====
// shared constants for the console control plane
// included by any RTL or testbench file that needs addresses or video constants

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

//////////////////////////////
// host bridge addresses
`define ADDR_DOWNLOAD   32'h0000_0000
`define ADDR_ROM_SIZE   32'h0000_0004
`define ADDR_ROM_TYPE   32'h0000_0008
`define ADDR_RAM_SIZE   32'h0000_000C
`define ADDR_RESET      32'h0000_0050
`define ADDR_CPU_TURBO  32'h0000_0080
`define ADDR_GSU_TURBO  32'h0000_0084
`define ADDR_DEADZONE   32'h0000_010C
`define ADDR_DEJITTER   32'h0000_0400
`define ADDR_YC         32'h0000_0410
`define ADDR_ADAPTER    32'hF700_0000

//////////////////////////////
// chroma subcarrier phase increments
// sized for the console video clock of the NTSC and PAL builds
`define NTSC_PHASE_INC  40'd183251916632
`define PAL_PHASE_INC   40'd229064922453

//////////////////////////////
// stick and reset button
`define STICK_CENTER         8'd128

// reset button pulse length in clk_74a cycles
`define RESET_DELAY_DEFAULT  32'h0010_0000

`endif

// ==== rtl/core_pkg.sv ====
// shared types of the console control plane
// referenced by scoped name from the RTL and testbench

package core_pkg;

  // one controller's buttons, up at bit 0 and start at bit 15
  typedef struct packed {
    logic start;
    logic select;
    logic r3;
    logic l3;
    logic r2;
    logic l2;
    logic r1;
    logic l1;
    logic y;
    logic x;
    logic b;
    logic a;
    logic right;
    logic left;
    logic down;
    logic up;
  } key_t;

  // unsigned axis, 128 at rest
  typedef logic [7:0] stick_t;

  // bit 3 blanks the handheld screen
  typedef logic [3:0] video_type_t;

  // zero disables the adapter controller port
  typedef logic [4:0] cont_type_t;

  typedef logic [3:0] cont_assign_t;

  typedef logic [39:0] phase_inc_t;

  // adapter settings word as written over the bridge
  typedef struct packed {
    video_type_t  video_type;
    cont_assign_t cont_assign;
    logic         spare;
    cont_type_t   cont_type;
  } adapter_settings_t;

endpackage

// ==== rtl/settings_regs.sv ====
// settings registers on the host bridge
// decodes bridge writes, serves the adapter readback, times the reset
// button pulse and derives the colour standard from the adapter video type

`include "core_defines.svh"

module settings_regs #(
  parameter int unsigned RESET_DELAY = `RESET_DELAY_DEFAULT
) (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  logic [31:0]               bridge_addr,
  input  logic                      bridge_wr,
  input  logic [31:0]               bridge_wr_data,
  output logic [31:0]               bridge_rd_data,
  output logic                      ioctl_download,
  output logic [3:0]                rom_size,
  output logic [7:0]                rom_type,
  output logic [3:0]                ram_size,
  output logic                      cpu_turbo,
  output logic                      gsu_turbo,
  output logic                      sync_dejitter,
  output logic                      yc_cvbs,
  output core_pkg::stick_t          deadzone,
  output core_pkg::cont_type_t      cont_type,
  output core_pkg::cont_assign_t    cont_assign,
  output logic                      pal_flag,
  output core_pkg::phase_inc_t      chroma_phase_inc,
  output logic                      pocket_blank,
  output logic                      core_reset
);

  core_pkg::adapter_settings_t adapter_settings;
  logic [31:0]                 reset_cnt;

  //////////////////////////////
  // bridge writes
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download   <= 1'b0;
      rom_size         <= '0;
      rom_type         <= '0;
      ram_size         <= '0;
      cpu_turbo        <= 1'b0;
      gsu_turbo        <= 1'b0;
      deadzone         <= '0;
      sync_dejitter    <= 1'b0;
      yc_cvbs          <= 1'b0;
      adapter_settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        `ADDR_DOWNLOAD:  ioctl_download   <= bridge_wr_data[0];
        `ADDR_ROM_SIZE:  rom_size         <= bridge_wr_data[3:0];
        `ADDR_ROM_TYPE:  rom_type         <= bridge_wr_data[7:0];
        `ADDR_RAM_SIZE:  ram_size         <= bridge_wr_data[3:0];
        `ADDR_CPU_TURBO: cpu_turbo        <= bridge_wr_data[0];
        `ADDR_GSU_TURBO: gsu_turbo        <= bridge_wr_data[0];
        `ADDR_DEADZONE:  deadzone         <= bridge_wr_data[7:0];
        `ADDR_DEJITTER:  sync_dejitter    <= bridge_wr_data[0];
        `ADDR_YC:        yc_cvbs          <= bridge_wr_data[0];
        `ADDR_ADAPTER:   adapter_settings <= bridge_wr_data[13:0];
        default: ;
      endcase
    end
  end

  // only the adapter word is readable
  assign bridge_rd_data = (bridge_addr == `ADDR_ADAPTER) ? {18'h0, adapter_settings} : '0;

  //////////////////////////////
  // reset button pulse
  // counter loads on the write, high for RESET_DELAY cycles after it
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (bridge_wr && bridge_addr == `ADDR_RESET) begin
      reset_cnt <= RESET_DELAY;
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 32'd1;
    end
  end

  assign core_reset = !pll_core_locked || (reset_cnt != '0);

  //////////////////////////////
  // adapter fields and colour standard
  assign cont_type   = adapter_settings.cont_type;
  assign cont_assign = adapter_settings.cont_assign;

  // types 4 and 12 are the PAL outputs, with and without screen blank
  assign pal_flag         = (adapter_settings.video_type == 4'h4) ||
                            (adapter_settings.video_type == 4'hC);
  assign chroma_phase_inc = pal_flag ? `PAL_PHASE_INC : `NTSC_PHASE_INC;
  assign pocket_blank     = adapter_settings.video_type[3];

endmodule

// ==== rtl/stick_deadzone.sv ====
// deadzone calibration of player one's left stick
// both axes snap to centre while the combined deflection is inside the deadzone

`include "core_defines.svh"

module stick_deadzone (
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  logic [31:0]      joy,
  input  core_pkg::stick_t deadzone,
  output core_pkg::stick_t stick_x,
  output core_pkg::stick_t stick_y
);

  core_pkg::stick_t axis_x;
  core_pkg::stick_t axis_y;
  logic [7:0]       dist_x;
  logic [7:0]       dist_y;
  logic [8:0]       dist_sum;
  logic             outside;

  // left stick sits in the low half of the joy word
  assign axis_x = joy[7:0];
  assign axis_y = joy[15:8];

  // rough distance from centre per axis
  assign dist_x = axis_x[7] ? {1'b0, axis_x[6:0]} : 8'd128 - {1'b0, axis_x[6:0]};
  assign dist_y = axis_y[7] ? {1'b0, axis_y[6:0]} : 8'd128 - {1'b0, axis_y[6:0]};

  assign dist_sum = {1'b0, dist_x} + {1'b0, dist_y};
  assign outside  = dist_sum > {1'b0, deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      stick_x <= `STICK_CENTER;
      stick_y <= `STICK_CENTER;
    end else begin
      stick_x <= outside ? axis_x : `STICK_CENTER;
      stick_y <= outside ? axis_y : `STICK_CENTER;
    end
  end

endmodule

// ==== rtl/player_router.sv ====
// routing of the four players between handheld and adapter controllers
// the adapter controller type and assignment mode pick the source of each
// player; outputs are registered

`include "core_defines.svh"

module player_router (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::cont_type_t   cont_type,
  input  core_pkg::cont_assign_t cont_assign,
  input  core_pkg::key_t         pocket_key1,
  input  core_pkg::key_t         pocket_key2,
  input  core_pkg::key_t         pocket_key3,
  input  core_pkg::key_t         pocket_key4,
  input  core_pkg::stick_t       pocket_stick_x,
  input  core_pkg::stick_t       pocket_stick_y,
  input  core_pkg::key_t         snac_p1_btn,
  input  core_pkg::key_t         snac_p2_btn,
  input  core_pkg::key_t         snac_p3_btn,
  input  core_pkg::key_t         snac_p4_btn,
  output core_pkg::key_t         p1_controls,
  output core_pkg::key_t         p2_controls,
  output core_pkg::key_t         p3_controls,
  output core_pkg::key_t         p4_controls,
  output core_pkg::stick_t       p1_stick_x,
  output core_pkg::stick_t       p1_stick_y
);

  core_pkg::key_t p1_next;
  core_pkg::key_t p2_next;
  core_pkg::key_t p3_next;
  core_pkg::key_t p4_next;
  logic           p1_from_snac;

  //////////////////////////////
  // source selection
  always_comb begin
    p1_next      = pocket_key1;
    p2_next      = pocket_key2;
    p3_next      = pocket_key3;
    p4_next      = pocket_key4;
    p1_from_snac = 1'b0;
    // adapter port disabled keeps the handheld layout
    if (cont_type != '0) begin
      case (cont_assign)
        4'd0: begin
          p1_next      = snac_p1_btn;
          p1_from_snac = 1'b1;
        end
        4'd1: begin
          p2_next = snac_p1_btn;
        end
        4'd2: begin
          p1_next      = snac_p1_btn;
          p2_next      = snac_p2_btn;
          p1_from_snac = 1'b1;
        end
        4'd3: begin
          p1_next      = snac_p2_btn;
          p2_next      = snac_p1_btn;
          p1_from_snac = 1'b1;
        end
        4'd4: begin
          p1_next      = snac_p1_btn;
          p2_next      = snac_p2_btn;
          p3_next      = snac_p3_btn;
          p4_next      = snac_p4_btn;
          p1_from_snac = 1'b1;
        end
        // reversed multitap order
        4'd5: begin
          p1_next      = snac_p4_btn;
          p2_next      = snac_p3_btn;
          p3_next      = snac_p2_btn;
          p4_next      = snac_p1_btn;
          p1_from_snac = 1'b1;
        end
        4'd6: begin
          p3_next = snac_p1_btn;
          p4_next = snac_p2_btn;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // output registers
  // adapter pads have no stick, so player one rests at centre
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1_controls <= '0;
      p2_controls <= '0;
      p3_controls <= '0;
      p4_controls <= '0;
      p1_stick_x  <= `STICK_CENTER;
      p1_stick_y  <= `STICK_CENTER;
    end else begin
      p1_controls <= p1_next;
      p2_controls <= p2_next;
      p3_controls <= p3_next;
      p4_controls <= p4_next;
      p1_stick_x  <= p1_from_snac ? `STICK_CENTER : pocket_stick_x;
      p1_stick_y  <= p1_from_snac ? `STICK_CENTER : pocket_stick_y;
    end
  end

endmodule

// ==== rtl/core_control_top.sv ====
// top of the console control plane
// joins the bridge settings, stick calibration and player routing

`include "core_defines.svh"

module core_control_top #(
  parameter int unsigned RESET_DELAY = `RESET_DELAY_DEFAULT
) (
  input  logic                 clk_74a,
  input  logic                 pll_core_locked,
  input  logic [31:0]          bridge_addr,
  input  logic                 bridge_wr,
  input  logic [31:0]          bridge_wr_data,
  output logic [31:0]          bridge_rd_data,
  input  core_pkg::key_t       pocket_key1,
  input  core_pkg::key_t       pocket_key2,
  input  core_pkg::key_t       pocket_key3,
  input  core_pkg::key_t       pocket_key4,
  input  logic [31:0]          cont1_joy,
  input  core_pkg::key_t       snac_p1_btn,
  input  core_pkg::key_t       snac_p2_btn,
  input  core_pkg::key_t       snac_p3_btn,
  input  core_pkg::key_t       snac_p4_btn,
  output logic                 ioctl_download,
  output logic [3:0]           rom_size,
  output logic [7:0]           rom_type,
  output logic [3:0]           ram_size,
  output logic                 cpu_turbo,
  output logic                 gsu_turbo,
  output logic                 sync_dejitter,
  output logic                 yc_cvbs,
  output logic                 pal_flag,
  output core_pkg::phase_inc_t chroma_phase_inc,
  output logic                 pocket_blank,
  output logic                 core_reset,
  output core_pkg::key_t       p1_controls,
  output core_pkg::key_t       p2_controls,
  output core_pkg::key_t       p3_controls,
  output core_pkg::key_t       p4_controls,
  output core_pkg::stick_t     p1_stick_x,
  output core_pkg::stick_t     p1_stick_y
);

  core_pkg::stick_t       deadzone;
  core_pkg::cont_type_t   cont_type;
  core_pkg::cont_assign_t cont_assign;
  core_pkg::stick_t       cal_stick_x;
  core_pkg::stick_t       cal_stick_y;

  settings_regs #(
    .RESET_DELAY (RESET_DELAY)
  ) settings_regs_inst (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .bridge_rd_data   (bridge_rd_data),
    .ioctl_download   (ioctl_download),
    .rom_size         (rom_size),
    .rom_type         (rom_type),
    .ram_size         (ram_size),
    .cpu_turbo        (cpu_turbo),
    .gsu_turbo        (gsu_turbo),
    .sync_dejitter    (sync_dejitter),
    .yc_cvbs          (yc_cvbs),
    .deadzone         (deadzone),
    .cont_type        (cont_type),
    .cont_assign      (cont_assign),
    .pal_flag         (pal_flag),
    .chroma_phase_inc (chroma_phase_inc),
    .pocket_blank     (pocket_blank),
    .core_reset       (core_reset)
  );

  // first stick stage
  stick_deadzone stick_deadzone_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .joy             (cont1_joy),
    .deadzone        (deadzone),
    .stick_x         (cal_stick_x),
    .stick_y         (cal_stick_y)
  );

  // second stick stage and button registers
  player_router player_router_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont_type       (cont_type),
    .cont_assign     (cont_assign),
    .pocket_key1     (pocket_key1),
    .pocket_key2     (pocket_key2),
    .pocket_key3     (pocket_key3),
    .pocket_key4     (pocket_key4),
    .pocket_stick_x  (cal_stick_x),
    .pocket_stick_y  (cal_stick_y),
    .snac_p1_btn     (snac_p1_btn),
    .snac_p2_btn     (snac_p2_btn),
    .snac_p3_btn     (snac_p3_btn),
    .snac_p4_btn     (snac_p4_btn),
    .p1_controls     (p1_controls),
    .p2_controls     (p2_controls),
    .p3_controls     (p3_controls),
    .p4_controls     (p4_controls),
    .p1_stick_x      (p1_stick_x),
    .p1_stick_y      (p1_stick_y)
  );

endmodule

// ==== testbench/core_control_properties.sv ====
// concurrent checks on the control plane top level
// bound into core_control_top; failures count up for the testbench summary

`include "core_defines.svh"

module core_control_properties (
  input logic                 clk_74a,
  input logic                 pll_core_locked,
  input logic                 core_reset,
  input core_pkg::phase_inc_t chroma_phase_inc,
  input core_pkg::key_t       p1_controls
);

  int assert_fails = 0;

  // the console core is held while the PLL is unlocked
  a_reset_while_unlocked: assert property (
    @(posedge clk_74a) !pll_core_locked |-> core_reset
  ) else begin
    assert_fails++;
    $error("core_reset low while pll_core_locked is low");
  end

  // only the two subcarrier constants are legal
  a_phase_constant: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (chroma_phase_inc == `NTSC_PHASE_INC) || (chroma_phase_inc == `PAL_PHASE_INC)
  ) else begin
    assert_fails++;
    $error("chroma_phase_inc is neither the NTSC nor the PAL increment");
  end

  a_p1_known: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) !$isunknown(p1_controls)
  ) else begin
    assert_fails++;
    $error("p1_controls has unknown bits");
  end

endmodule

bind core_control_top core_control_properties core_control_properties_inst (
  .clk_74a          (clk_74a),
  .pll_core_locked  (pll_core_locked),
  .core_reset       (core_reset),
  .chroma_phase_inc (chroma_phase_inc),
  .p1_controls      (p1_controls)
);

// ==== testbench/core_control_tb.sv ====
// testbench for the console control plane top level
// runs a table of bridge, video, reset, stick and routing entries against the DUT
// and prints one line per test followed by the totals

`include "core_defines.svh"

module core_control_tb;

  localparam int OP_SET = 0;
  localparam int OP_READ = 1;
  localparam int OP_VIDEO = 2;
  localparam int OP_PULSE = 3;
  localparam int OP_STICK = 4;
  localparam int OP_ROUTE = 5;
  localparam int TIMEOUT_CYCLES = 64;

  logic                 clk_74a;
  logic                 pll_core_locked;
  logic [31:0]          bridge_addr;
  logic                 bridge_wr;
  logic [31:0]          bridge_wr_data;
  logic [31:0]          bridge_rd_data;
  logic [31:0]          cont1_joy;
  core_pkg::key_t       pocket_key [4];
  core_pkg::key_t       snac_btn [4];
  logic                 ioctl_download;
  logic [3:0]           rom_size;
  logic [7:0]           rom_type;
  logic [3:0]           ram_size;
  logic                 cpu_turbo;
  logic                 gsu_turbo;
  logic                 sync_dejitter;
  logic                 yc_cvbs;
  logic                 pal_flag;
  core_pkg::phase_inc_t chroma_phase_inc;
  logic                 pocket_blank;
  logic                 core_reset;
  core_pkg::key_t       p1_controls;
  core_pkg::key_t       p2_controls;
  core_pkg::key_t       p3_controls;
  core_pkg::key_t       p4_controls;
  core_pkg::stick_t     p1_stick_x;
  core_pkg::stick_t     p1_stick_y;

  integer           seed = 32'h68bb4b92;
  int               errors = 0;
  int               checks = 0;
  core_pkg::stick_t last_x = `STICK_CENTER;
  core_pkg::stick_t last_y = `STICK_CENTER;

  // stimulus table, one column per queue
  int          op_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  logic [31:0] exp_q [$];

  core_control_top #(
    .RESET_DELAY (16)
  ) core_control_top_inst (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .bridge_rd_data   (bridge_rd_data),
    .pocket_key1      (pocket_key[0]),
    .pocket_key2      (pocket_key[1]),
    .pocket_key3      (pocket_key[2]),
    .pocket_key4      (pocket_key[3]),
    .cont1_joy        (cont1_joy),
    .snac_p1_btn      (snac_btn[0]),
    .snac_p2_btn      (snac_btn[1]),
    .snac_p3_btn      (snac_btn[2]),
    .snac_p4_btn      (snac_btn[3]),
    .ioctl_download   (ioctl_download),
    .rom_size         (rom_size),
    .rom_type         (rom_type),
    .ram_size         (ram_size),
    .cpu_turbo        (cpu_turbo),
    .gsu_turbo        (gsu_turbo),
    .sync_dejitter    (sync_dejitter),
    .yc_cvbs          (yc_cvbs),
    .pal_flag         (pal_flag),
    .chroma_phase_inc (chroma_phase_inc),
    .pocket_blank     (pocket_blank),
    .core_reset       (core_reset),
    .p1_controls      (p1_controls),
    .p2_controls      (p2_controls),
    .p3_controls      (p3_controls),
    .p4_controls      (p4_controls),
    .p1_stick_x       (p1_stick_x),
    .p1_stick_y       (p1_stick_y)
  );

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // compare tasks
  task automatic check_key(input core_pkg::key_t got, input core_pkg::key_t exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_stick(input core_pkg::stick_t got, input core_pkg::stick_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_phase(input core_pkg::phase_inc_t got, input core_pkg::phase_inc_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // helpers
  task automatic add_entry(input int op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  // one-cycle write strobe, returns just after the updating edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    #1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(posedge clk_74a);
    #1;
    bridge_wr = 1'b0;
  endtask

  // the DUT output that a setting address drives, zero-extended
  function automatic logic [31:0] setting_out(input logic [31:0] addr);
    case (addr)
      `ADDR_DOWNLOAD:  return {31'h0, ioctl_download};
      `ADDR_ROM_SIZE:  return {28'h0, rom_size};
      `ADDR_ROM_TYPE:  return {24'h0, rom_type};
      `ADDR_RAM_SIZE:  return {28'h0, ram_size};
      `ADDR_CPU_TURBO: return {31'h0, cpu_turbo};
      `ADDR_GSU_TURBO: return {31'h0, gsu_turbo};
      `ADDR_DEJITTER:  return {31'h0, sync_dejitter};
      `ADDR_YC:        return {31'h0, yc_cvbs};
      `ADDR_ADAPTER:   return bridge_rd_data;
      default:         return 32'h0;
    endcase
  endfunction

  // source of players one to four, one nibble each, player one on top
  // 0 to 3 pick a handheld key, 4 to 7 an adapter pad; mode 8 is port disabled
  function automatic logic [15:0] route_sources(input int mode);
    case (mode)
      0:       return 16'h4123;
      1:       return 16'h0423;
      2:       return 16'h4523;
      3:       return 16'h5423;
      4:       return 16'h4567;
      5:       return 16'h7654;
      6:       return 16'h0145;
      default: return 16'h0123;
    endcase
  endfunction

  function automatic core_pkg::key_t player_out(input int k);
    case (k)
      0:       return p1_controls;
      1:       return p2_controls;
      2:       return p3_controls;
      default: return p4_controls;
    endcase
  endfunction

  //////////////////////////////
  // table operations
  task automatic run_video(input logic [31:0] data, input logic [31:0] exp);
    bus_write(`ADDR_ADAPTER, data);
    @(negedge clk_74a);
    check_word({31'h0, pal_flag}, {31'h0, exp[0]}, "pal_flag");
    check_word({31'h0, pocket_blank}, {31'h0, exp[1]}, "pocket_blank");
    check_phase(chroma_phase_inc, exp[0] ? `PAL_PHASE_INC : `NTSC_PHASE_INC, "chroma_phase_inc");
  endtask

  task automatic run_pulse(input logic [31:0] exp);
    int   high_cycles;
    int   waited;
    logic done;
    bus_write(`ADDR_RESET, 32'h0);
    high_cycles = 0;
    waited      = 0;
    done        = 1'b0;
    while (!done && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_74a);
      waited++;
      if (core_reset) begin
        high_cycles++;
      end else if (high_cycles > 0) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("timeout: core_reset pulse did not end within %0d cycles", TIMEOUT_CYCLES);
      errors++;
    end else begin
      check_word(high_cycles, exp, "core_reset pulse length");
    end
  endtask

  // deadzone in data bits 23..16, joy y and x below; expected y and x in exp
  task automatic run_stick(input logic [31:0] data, input logic [31:0] exp);
    bus_write(`ADDR_DEADZONE, {24'h0, data[23:16]});
    cont1_joy = {16'h0, data[15:0]};
    @(posedge clk_74a);
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_stick(p1_stick_x, exp[7:0], "p1_stick_x");
    check_stick(p1_stick_y, exp[15:8], "p1_stick_y");
    last_x = exp[7:0];
    last_y = exp[15:8];
  endtask

  task automatic run_route(input logic [31:0] data, input int mode);
    logic [15:0]    srcs;
    logic [31:0]    rnd;
    int             src;
    int             k;
    core_pkg::key_t exp_key;
    bus_write(`ADDR_ADAPTER, data);
    for (k = 0; k < 4; k++) begin
      rnd = $random(seed);
      pocket_key[k] = rnd[15:0];
      snac_btn[k]   = rnd[31:16];
    end
    @(posedge clk_74a);
    @(negedge clk_74a);
    srcs = route_sources(mode);
    for (k = 0; k < 4; k++) begin
      src = srcs[15 - 4 * k -: 4];
      exp_key = (src < 4) ? pocket_key[src] : snac_btn[src - 4];
      check_key(player_out(k), exp_key, $sformatf("mode %0d player %0d", mode, k + 1));
    end
    // adapter pads carry no stick
    check_stick(p1_stick_x, (srcs[15:12] >= 4) ? `STICK_CENTER : last_x, "routed stick x");
    check_stick(p1_stick_y, (srcs[15:12] >= 4) ? `STICK_CENTER : last_y, "routed stick y");
  endtask

  task automatic build_table();
    int a;
    add_entry(OP_SET, `ADDR_DOWNLOAD, 32'h1, 32'h1);
    add_entry(OP_SET, `ADDR_ROM_SIZE, 32'hFFFF_FFFA, 32'hA);
    add_entry(OP_SET, `ADDR_ROM_TYPE, 32'h1234, 32'h34);
    add_entry(OP_SET, `ADDR_RAM_SIZE, 32'h7, 32'h7);
    add_entry(OP_SET, `ADDR_CPU_TURBO, 32'h1, 32'h1);
    add_entry(OP_SET, `ADDR_GSU_TURBO, 32'h3, 32'h1);
    add_entry(OP_SET, `ADDR_DEJITTER, 32'h1, 32'h1);
    add_entry(OP_SET, `ADDR_YC, 32'h2, 32'h0);
    add_entry(OP_SET, `ADDR_YC, 32'h1, 32'h1);
    add_entry(OP_SET, `ADDR_ADAPTER, 32'hFFFF_FFFF, 32'h3FFF);
    add_entry(OP_READ, `ADDR_ADAPTER, 32'h0, 32'h3FFF);
    add_entry(OP_READ, `ADDR_ROM_SIZE, 32'h0, 32'h0);
    add_entry(OP_READ, `ADDR_DEADZONE, 32'h0, 32'h0);
    add_entry(OP_READ, `ADDR_RESET, 32'h0, 32'h0);
    // video type in bits 13..10; expected blank in bit 1 and PAL in bit 0
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h0000, 32'h0);
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h1000, 32'h1);
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h1400, 32'h0);
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h2000, 32'h2);
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h3000, 32'h3);
    add_entry(OP_VIDEO, `ADDR_ADAPTER, 32'h3C00, 32'h2);
    add_entry(OP_PULSE, `ADDR_RESET, 32'h0, 32'd16);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h14_7C84, 32'h8080);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h14_7A8A, 32'h8080);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h14_768A, 32'h8080);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h14_768B, 32'h768B);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h00_8081, 32'h8081);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h00_8080, 32'h8080);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'hC8_00FF, 32'h00FF);
    add_entry(OP_STICK, `ADDR_DEADZONE, 32'h1E_E020, 32'hE020);
    // port disabled, then controller type 1 with each assignment
    add_entry(OP_ROUTE, `ADDR_ADAPTER, 32'h0080, 32'd8);
    for (a = 0; a < 8; a++) begin
      add_entry(OP_ROUTE, `ADDR_ADAPTER, (a << 6) | 32'h1, a);
    end
  endtask

  function automatic string op_name(input int op);
    case (op)
      OP_SET:   return "setting write";
      OP_READ:  return "bridge read";
      OP_VIDEO: return "video standard";
      OP_PULSE: return "reset pulse";
      OP_STICK: return "stick deadzone";
      default:  return "player routing";
    endcase
  endfunction

  //////////////////////////////
  // main sequence
  initial begin
    int i;
    int k;
    int errs_before;
    int assert_fails;
    pll_core_locked = 1'b0;
    bridge_addr     = `ADDR_ADAPTER;
    bridge_wr       = 1'b0;
    bridge_wr_data  = 32'h0;
    cont1_joy       = 32'h0000_8080;
    for (k = 0; k < 4; k++) begin
      pocket_key[k] = '0;
      snac_btn[k]   = '0;
    end
    build_table();

    repeat (4) @(posedge clk_74a);
    @(negedge clk_74a);
    check_word({31'h0, core_reset}, 32'h1, "core_reset while unlocked");
    @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    @(negedge clk_74a);
    check_word({8'h0, ioctl_download, rom_size, rom_type, ram_size, cpu_turbo, gsu_turbo,
                sync_dejitter, yc_cvbs, pal_flag, pocket_blank, core_reset},
               32'h0, "settings after reset");
    check_phase(chroma_phase_inc, `NTSC_PHASE_INC, "phase after reset");
    for (k = 0; k < 4; k++) begin
      check_key(player_out(k), '0, $sformatf("player %0d after reset", k + 1));
    end
    check_stick(p1_stick_x, `STICK_CENTER, "stick x after reset");
    check_stick(p1_stick_y, `STICK_CENTER, "stick y after reset");
    check_word(bridge_rd_data, 32'h0, "readback after reset");
    $display("test reset state: %s", (errors == 0) ? "pass" : "fail");

    for (i = 0; i < op_q.size(); i++) begin
      errs_before = errors;
      case (op_q[i])
        OP_SET: begin
          bus_write(addr_q[i], data_q[i]);
          @(negedge clk_74a);
          check_word(setting_out(addr_q[i]), exp_q[i], $sformatf("setting %h", addr_q[i]));
        end
        OP_READ: begin
          @(posedge clk_74a);
          #1;
          bridge_addr = addr_q[i];
          @(negedge clk_74a);
          check_word(bridge_rd_data, exp_q[i], $sformatf("readback %h", addr_q[i]));
        end
        OP_VIDEO: run_video(data_q[i], exp_q[i]);
        OP_PULSE: run_pulse(exp_q[i]);
        OP_STICK: run_stick(data_q[i], exp_q[i]);
        default:  run_route(data_q[i], exp_q[i]);
      endcase
      $display("test %0d %s: %s", i, op_name(op_q[i]), (errors == errs_before) ? "pass" : "fail");
    end

    assert_fails = core_control_top_inst.core_control_properties_inst.assert_fails;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             op_q.size() + 1, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/settings_regs.sv
rtl/stick_deadzone.sv
rtl/player_router.sv
rtl/core_control_top.sv
testbench/core_control_properties.sv
testbench/core_control_tb.sv

// ==== Bender.yml ====
package:
  name: core_control

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/settings_regs.sv
      - rtl/stick_deadzone.sv
      - rtl/player_router.sv
      - rtl/core_control_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/core_control_properties.sv
      - testbench/core_control_tb.sv
